/* project.f */
src/rs_pkg.sv
src/pe_mult.sv
src/rs_alloc.sv
src/rs_entry_array.sv
src/rs_issue_select.sv
src/rs_top.sv
verification/rs_props.sv
verification/rs_tb.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the reservation station testbench with Verilator.
# Exit status is 0 only when the log holds the pass line.
set -u
cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert --top-module rs_tb -f project.f \
    -Mdir "$BUILD_DIR" -o rs_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$BUILD_DIR/rs_sim" > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if grep -q "^TEST PASSED$" "$LOG"; then
    exit 0
fi
exit 1

/* verification/rs_tb.sv */
/*
 * Table-driven testbench for the reservation station.
 * Each row is one clock cycle: stimulus driven at the rising edge and the
 * outputs expected in that cycle, checked at the falling edge.
 */
`timescale 1ns/1ps

module rs_tb;

    import rs_pkg::*;

    localparam int CLK_PERIOD = 8;
    localparam int RST_CYCLES = 5;

    // One dispatched instruction
    typedef struct packed {
        fu_t  fu;
        tag_t dest;
        tag_t src1;
        logic rdy1;
        tag_t src2;
        logic rdy2;
    } instr_t;

    // One cycle of stimulus and expected outputs
    typedef struct packed {
        dp_cnt_t             dp_num;
        instr_t [DP_NUM-1:0] ins;
        logic [CDB_NUM-1:0]  cdb_v;
        tag_t [CDB_NUM-1:0]  cdb_tag;
        logic [FU_NUM-1:0]   fu_rdy;
        logic                flush;
        dp_cnt_t             exp_avail;
        logic [IS_NUM-1:0]   exp_v;
        tag_t [IS_NUM-1:0]   exp_dest;
    } row_t;

    logic                 clk_i;
    logic                 rst_i;
    logic                 flush_i;
    dp_cnt_t              dp_num_i;
    fu_t  [DP_NUM-1:0]    dp_fu_i;
    tag_t [DP_NUM-1:0]    dp_tag_i;
    tag_t [DP_NUM-1:0]    dp_src1_tag_i;
    logic [DP_NUM-1:0]    dp_src1_rdy_i;
    tag_t [DP_NUM-1:0]    dp_src2_tag_i;
    logic [DP_NUM-1:0]    dp_src2_rdy_i;
    dp_cnt_t              avail_num_o;
    logic [CDB_NUM-1:0]   cdb_valid_i;
    tag_t [CDB_NUM-1:0]   cdb_tag_i;
    logic [FU_NUM-1:0]    fu_ready_i;
    logic [IS_NUM-1:0]    is_valid_o;
    fu_t  [IS_NUM-1:0]    is_fu_o;
    tag_t [IS_NUM-1:0]    is_tag_o;
    tag_t [IS_NUM-1:0]    is_src1_tag_o;
    tag_t [IS_NUM-1:0]    is_src2_tag_o;

    row_t rows[$];
    row_t cur;
    // Instructions seen at dispatch indexed by dest tag
    fu_t  sent_fu   [2**TAG_W];
    tag_t sent_src1 [2**TAG_W];
    tag_t sent_src2 [2**TAG_W];
    bit   run_done;
    bit   fail_shown;

    rs_top u_rs_top (.*);

    initial begin
        clk_i = 1'b0;
        forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
    end

    // ------------------------------
    // Failure and compare tasks
    // ------------------------------
    task automatic fail_now(string msg);
        $display("%s", msg);
        fail_shown = 1'b1;
        $display("TEST FAILED");
        $fatal(1, "run stopped");
    endtask

    task automatic check_cnt(string name, dp_cnt_t exp, dp_cnt_t act);
        if (act !== exp) begin
            fail_now($sformatf("[ERROR] %s expected 0x%0h actual 0x%0h", name, exp, act));
        end
    endtask

    task automatic check_tag(string name, tag_t exp, tag_t act);
        if (act !== exp) begin
            fail_now($sformatf("[ERROR] %s expected 0x%0h actual 0x%0h", name, exp, act));
        end
    endtask

    task automatic check_fu(string name, fu_t exp, fu_t act);
        if (act !== exp) begin
            fail_now($sformatf("[ERROR] %s expected 0x%0h actual 0x%0h", name, exp, act));
        end
    endtask

    task automatic check_bit(string name, logic exp, logic act);
        if (act !== exp) begin
            fail_now($sformatf("[ERROR] %s expected 0x%0h actual 0x%0h", name, exp, act));
        end
    endtask

    // ------------------------------
    // Table building
    // ------------------------------
    function automatic instr_t make_instr(fu_t fu, tag_t dest, tag_t src1, logic rdy1,
                                          tag_t src2, logic rdy2);
        return {fu, dest, src1, rdy1, src2, rdy2};
    endfunction

    // Idle cycle with all units ready
    task automatic clear_row();
        cur        = '0;
        cur.fu_rdy = '1;
    endtask

    task automatic set_dispatch(dp_cnt_t n, instr_t i0, instr_t i1);
        cur.dp_num = n;
        cur.ins[0] = i0;
        cur.ins[1] = i1;
    endtask

    task automatic set_cdb(logic [CDB_NUM-1:0] v, tag_t t0, tag_t t1);
        cur.cdb_v      = v;
        cur.cdb_tag[0] = t0;
        cur.cdb_tag[1] = t1;
    endtask

    // Expected outputs close the row
    task automatic add_row(dp_cnt_t avail, logic [IS_NUM-1:0] v, tag_t d0, tag_t d1);
        cur.exp_avail   = avail;
        cur.exp_v       = v;
        cur.exp_dest[0] = d0;
        cur.exp_dest[1] = d1;
        rows.push_back(cur);
        clear_row();
    endtask

    task automatic build_table();
        instr_t nop;
        nop = '0;
        clear_row();
        // Empty after reset
        add_row(2'd2, 2'b00, 6'h00, 6'h00);
        // Two ready instructions issue next cycle in slot order and then leave
        set_dispatch(2'd2, make_instr(FU_ALU, 6'h01, 6'h10, 1'b1, 6'h11, 1'b1),
                     make_instr(FU_MULT, 6'h02, 6'h12, 1'b1, 6'h13, 1'b1));
        add_row(2'd2, 2'b00, 6'h00, 6'h00);
        add_row(2'd2, 2'b11, 6'h01, 6'h02);
        add_row(2'd2, 2'b00, 6'h00, 6'h00);
        // Wakeup of src2 after a foreign tag
        set_dispatch(2'd1, make_instr(FU_ALU, 6'h03, 6'h14, 1'b1, 6'h20, 1'b0), nop);
        add_row(2'd2, 2'b00, 6'h00, 6'h00);
        set_cdb(2'b01, 6'h21, 6'h00);
        add_row(2'd2, 2'b00, 6'h00, 6'h00);
        set_cdb(2'b10, 6'h00, 6'h20);
        add_row(2'd2, 2'b00, 6'h00, 6'h00);
        add_row(2'd2, 2'b01, 6'h03, 6'h00);
        add_row(2'd2, 2'b00, 6'h00, 6'h00);
        // Later ALU op passes the busy multiplier (bit 1 low)
        set_dispatch(2'd2, make_instr(FU_MULT, 6'h04, 6'h15, 1'b1, 6'h16, 1'b1),
                     make_instr(FU_ALU, 6'h05, 6'h17, 1'b1, 6'h18, 1'b1));
        cur.fu_rdy = 5'b11101;
        add_row(2'd2, 2'b00, 6'h00, 6'h00);
        cur.fu_rdy = 5'b11101;
        add_row(2'd2, 2'b01, 6'h05, 6'h00);
        cur.fu_rdy = 5'b11101;
        add_row(2'd2, 2'b00, 6'h00, 6'h00);
        add_row(2'd2, 2'b01, 6'h04, 6'h00);
        add_row(2'd2, 2'b00, 6'h00, 6'h00);
        // Three held multiplies issue two and then one
        set_dispatch(2'd2, make_instr(FU_MULT, 6'h06, 6'h19, 1'b1, 6'h1a, 1'b1),
                     make_instr(FU_MULT, 6'h07, 6'h1b, 1'b1, 6'h1c, 1'b1));
        cur.fu_rdy = 5'b11101;
        add_row(2'd2, 2'b00, 6'h00, 6'h00);
        set_dispatch(2'd1, make_instr(FU_MULT, 6'h08, 6'h1d, 1'b1, 6'h1e, 1'b1), nop);
        cur.fu_rdy = 5'b11101;
        add_row(2'd2, 2'b00, 6'h00, 6'h00);
        cur.fu_rdy = 5'b11101;
        add_row(2'd2, 2'b00, 6'h00, 6'h00);
        add_row(2'd2, 2'b11, 6'h06, 6'h07);
        add_row(2'd2, 2'b01, 6'h08, 6'h00);
        add_row(2'd2, 2'b00, 6'h00, 6'h00);
        // Fill all eight entries with waiting ops
        set_dispatch(2'd2, make_instr(FU_ALU, 6'h09, 6'h10, 1'b1, 6'h30, 1'b0),
                     make_instr(FU_ALU, 6'h0a, 6'h11, 1'b1, 6'h31, 1'b0));
        add_row(2'd2, 2'b00, 6'h00, 6'h00);
        set_dispatch(2'd2, make_instr(FU_LOAD, 6'h0b, 6'h12, 1'b1, 6'h32, 1'b0),
                     make_instr(FU_STORE, 6'h0c, 6'h13, 1'b1, 6'h33, 1'b0));
        add_row(2'd2, 2'b00, 6'h00, 6'h00);
        set_dispatch(2'd2, make_instr(FU_BR, 6'h0d, 6'h14, 1'b1, 6'h34, 1'b0),
                     make_instr(FU_ALU, 6'h0e, 6'h15, 1'b1, 6'h35, 1'b0));
        add_row(2'd2, 2'b00, 6'h00, 6'h00);
        set_dispatch(2'd2, make_instr(FU_MULT, 6'h0f, 6'h16, 1'b1, 6'h36, 1'b0),
                     make_instr(FU_ALU, 6'h10, 6'h17, 1'b1, 6'h37, 1'b0));
        add_row(2'd2, 2'b00, 6'h00, 6'h00);
        add_row(2'd0, 2'b00, 6'h00, 6'h00);
        // Wake entry 3 only
        set_cdb(2'b01, 6'h33, 6'h00);
        add_row(2'd0, 2'b00, 6'h00, 6'h00);
        // Full station refills entry 3 on the edge that releases it
        set_dispatch(2'd1, make_instr(FU_ALU, 6'h14, 6'h20, 1'b1, 6'h21, 1'b1), nop);
        add_row(2'd1, 2'b01, 6'h0c, 6'h00);
        add_row(2'd1, 2'b01, 6'h14, 6'h00);
        // Waiting tags broadcast after a flush have no effect
        cur.flush = 1'b1;
        add_row(2'd1, 2'b00, 6'h00, 6'h00);
        add_row(2'd2, 2'b00, 6'h00, 6'h00);
        set_cdb(2'b11, 6'h30, 6'h31);
        add_row(2'd2, 2'b00, 6'h00, 6'h00);
        add_row(2'd2, 2'b00, 6'h00, 6'h00);
        // Dispatch in a cycle where both channels issue
        set_dispatch(2'd2, make_instr(FU_ALU, 6'h11, 6'h18, 1'b1, 6'h19, 1'b1),
                     make_instr(FU_ALU, 6'h12, 6'h1a, 1'b1, 6'h1b, 1'b1));
        add_row(2'd2, 2'b00, 6'h00, 6'h00);
        set_dispatch(2'd1, make_instr(FU_BR, 6'h13, 6'h1c, 1'b1, 6'h1d, 1'b1), nop);
        add_row(2'd2, 2'b11, 6'h11, 6'h12);
        add_row(2'd2, 2'b01, 6'h13, 6'h00);
        add_row(2'd2, 2'b00, 6'h00, 6'h00);
    endtask

    // ------------------------------
    // Row drive and check
    // ------------------------------
    task automatic drive_row(row_t r);
        flush_i     <= r.flush;
        dp_num_i    <= r.dp_num;
        cdb_valid_i <= r.cdb_v;
        cdb_tag_i   <= r.cdb_tag;
        fu_ready_i  <= r.fu_rdy;
        for (int s = 0; s < DP_NUM; s++) begin
            dp_fu_i[s]       <= r.ins[s].fu;
            dp_tag_i[s]      <= r.ins[s].dest;
            dp_src1_tag_i[s] <= r.ins[s].src1;
            dp_src1_rdy_i[s] <= r.ins[s].rdy1;
            dp_src2_tag_i[s] <= r.ins[s].src2;
            dp_src2_rdy_i[s] <= r.ins[s].rdy2;
            if (s < int'(r.dp_num)) begin
                sent_fu[r.ins[s].dest]   = r.ins[s].fu;
                sent_src1[r.ins[s].dest] = r.ins[s].src1;
                sent_src2[r.ins[s].dest] = r.ins[s].src2;
            end
        end
    endtask

    task automatic check_row(row_t r);
        tag_t d;
        check_cnt("avail_num_o", r.exp_avail, avail_num_o);
        for (int c = 0; c < IS_NUM; c++) begin
            check_bit($sformatf("is_valid_o[%0d]", c), r.exp_v[c], is_valid_o[c]);
            if (r.exp_v[c]) begin
                d = r.exp_dest[c];
                check_tag($sformatf("is_tag_o[%0d]", c), d, is_tag_o[c]);
                check_fu($sformatf("is_fu_o[%0d]", c), sent_fu[d], is_fu_o[c]);
                check_tag($sformatf("is_src1_tag_o[%0d]", c), sent_src1[d], is_src1_tag_o[c]);
                check_tag($sformatf("is_src2_tag_o[%0d]", c), sent_src2[d], is_src2_tag_o[c]);
            end
        end
    endtask

    // ------------------------------
    // Main sequence
    // ------------------------------
    initial begin
        rst_i         = 1'b1;
        flush_i       = 1'b0;
        dp_num_i      = '0;
        dp_tag_i      = '0;
        dp_src1_tag_i = '0;
        dp_src1_rdy_i = '0;
        dp_src2_tag_i = '0;
        dp_src2_rdy_i = '0;
        cdb_valid_i   = '0;
        cdb_tag_i     = '0;
        fu_ready_i    = '1;
        for (int s = 0; s < DP_NUM; s++) begin
            dp_fu_i[s] = FU_ALU;
        end
        build_table();
        repeat (RST_CYCLES) @(posedge clk_i);
        rst_i <= 1'b0;
        foreach (rows[k]) begin
            @(posedge clk_i);
            drive_row(rows[k]);
            // Outputs settled half a cycle later
            @(negedge clk_i);
            check_row(rows[k]);
        end
        run_done = 1'b1;
        $display("TEST PASSED");
        $finish;
    end

    // Watchdog sized from the table length
    initial begin
        #1;
        #((rows.size() + 20) * CLK_PERIOD);
        fail_now("Timeout: the stimulus table did not finish in time");
    end

    // Run stopped by an assertion or the simulator
    final begin
        if (!run_done && !fail_shown) begin
            $display("TEST FAILED");
        end
    end

endmodule

/* verification/rs_props.sv */
/*
 * Concurrent assertions on the reservation station outputs.
 * Bound into rs_top by the bind statement at the end of this file.
 */
`timescale 1ns/1ps

module rs_props (
    input  logic                                clk_i,
    input  logic                                rst_i,
    input  logic [rs_pkg::FU_NUM-1:0]           fu_ready_i,
    input  logic [rs_pkg::IS_NUM-1:0]           is_valid_i,
    input  rs_pkg::fu_t [rs_pkg::IS_NUM-1:0]    is_fu_i,
    input  rs_pkg::dp_cnt_t                     avail_num_i
);

    import rs_pkg::*;

    // Channels fill from 0 upward
    a_fill_order: assert property (@(posedge clk_i) disable iff (rst_i)
        is_valid_i[1] |-> is_valid_i[0])
        else $error("issue channel 1 valid while channel 0 is idle");

    // Never issue to a busy unit
    for (genvar c = 0; c < IS_NUM; c++) begin : g_chan
        a_unit_ready: assert property (@(posedge clk_i) disable iff (rst_i)
            is_valid_i[c] |-> fu_ready_i[is_fu_i[c]])
            else $error("issue channel %0d sent to a unit that is not ready", c);
    end

    // Saturated at the dispatch width
    a_avail_max: assert property (@(posedge clk_i) disable iff (rst_i)
        avail_num_i <= dp_cnt_t'(DP_NUM))
        else $error("avail_num_o above the dispatch width");

    // Empty station right after reset
    a_reset_empty: assert property (@(posedge clk_i)
        rst_i |=> (is_valid_i == '0))
        else $error("issue channel valid in the cycle after reset");

endmodule

bind rs_top rs_props u_rs_props (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .fu_ready_i  (fu_ready_i),
    .is_valid_i  (is_valid_o),
    .is_fu_i     (is_fu_o),
    .avail_num_i (avail_num_o)
);

/* src/rs_top.sv */
/*
 * Reservation station top level for a single thread.
 * Connects allocation, entry storage and issue selection.
 */
`timescale 1ns/1ps

module rs_top (
    input  logic                                    clk_i,
    input  logic                                    rst_i,
    input  logic                                    flush_i,
    // Dispatch
    input  rs_pkg::dp_cnt_t                         dp_num_i,
    input  rs_pkg::fu_t  [rs_pkg::DP_NUM-1:0]       dp_fu_i,
    input  rs_pkg::tag_t [rs_pkg::DP_NUM-1:0]       dp_tag_i,
    input  rs_pkg::tag_t [rs_pkg::DP_NUM-1:0]       dp_src1_tag_i,
    input  logic [rs_pkg::DP_NUM-1:0]               dp_src1_rdy_i,
    input  rs_pkg::tag_t [rs_pkg::DP_NUM-1:0]       dp_src2_tag_i,
    input  logic [rs_pkg::DP_NUM-1:0]               dp_src2_rdy_i,
    output rs_pkg::dp_cnt_t                         avail_num_o,
    // Common data bus
    input  logic [rs_pkg::CDB_NUM-1:0]              cdb_valid_i,
    input  rs_pkg::tag_t [rs_pkg::CDB_NUM-1:0]      cdb_tag_i,
    // Issue
    input  logic [rs_pkg::FU_NUM-1:0]               fu_ready_i,
    output logic [rs_pkg::IS_NUM-1:0]               is_valid_o,
    output rs_pkg::fu_t  [rs_pkg::IS_NUM-1:0]       is_fu_o,
    output rs_pkg::tag_t [rs_pkg::IS_NUM-1:0]       is_tag_o,
    output rs_pkg::tag_t [rs_pkg::IS_NUM-1:0]       is_src1_tag_o,
    output rs_pkg::tag_t [rs_pkg::IS_NUM-1:0]       is_src2_tag_o
);

    import rs_pkg::*;

    rs_entry_t [RS_ENTRIES-1:0] entries;
    logic [RS_ENTRIES-1:0]      entry_valid;
    logic [RS_ENTRIES-1:0]      issue_sel;
    logic [DP_NUM-1:0]          dp_sel;
    rs_idx_t [DP_NUM-1:0]       dp_entry;

    for (genvar i = 0; i < RS_ENTRIES; i++) begin : g_valid
        assign entry_valid[i] = entries[i].valid;
    end

    rs_alloc u_rs_alloc (
        .dp_num_i      (dp_num_i),
        .entry_valid_i (entry_valid),
        .issue_sel_i   (issue_sel),
        .dp_sel_o      (dp_sel),
        .dp_entry_o    (dp_entry),
        .avail_num_o   (avail_num_o)
    );

    rs_entry_array u_rs_entry_array (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .flush_i       (flush_i),
        .dp_fu_i       (dp_fu_i),
        .dp_tag_i      (dp_tag_i),
        .dp_src1_tag_i (dp_src1_tag_i),
        .dp_src1_rdy_i (dp_src1_rdy_i),
        .dp_src2_tag_i (dp_src2_tag_i),
        .dp_src2_rdy_i (dp_src2_rdy_i),
        .dp_sel_i      (dp_sel),
        .dp_entry_i    (dp_entry),
        .cdb_valid_i   (cdb_valid_i),
        .cdb_tag_i     (cdb_tag_i),
        .issue_sel_i   (issue_sel),
        .entries_o     (entries)
    );

    rs_issue_select u_rs_issue_select (
        .entries_i     (entries),
        .fu_ready_i    (fu_ready_i),
        .issue_sel_o   (issue_sel),
        .is_valid_o    (is_valid_o),
        .is_fu_o       (is_fu_o),
        .is_tag_o      (is_tag_o),
        .is_src1_tag_o (is_src1_tag_o),
        .is_src2_tag_o (is_src2_tag_o)
    );

endmodule

/* src/rs_issue_select.sv */
/*
 * Issue selection.
 * Finds entries with both sources and their unit ready, sends the lowest
 * IS_NUM of them to the issue channels and returns the release mask.
 */
`timescale 1ns/1ps

module rs_issue_select (
    input  rs_pkg::rs_entry_t [rs_pkg::RS_ENTRIES-1:0] entries_i,
    input  logic [rs_pkg::FU_NUM-1:0]               fu_ready_i,
    output logic [rs_pkg::RS_ENTRIES-1:0]           issue_sel_o,
    output logic [rs_pkg::IS_NUM-1:0]               is_valid_o,
    output rs_pkg::fu_t  [rs_pkg::IS_NUM-1:0]       is_fu_o,
    output rs_pkg::tag_t [rs_pkg::IS_NUM-1:0]       is_tag_o,
    output rs_pkg::tag_t [rs_pkg::IS_NUM-1:0]       is_src1_tag_o,
    output rs_pkg::tag_t [rs_pkg::IS_NUM-1:0]       is_src2_tag_o
);

    import rs_pkg::*;

    logic [RS_ENTRIES-1:0]         ready_vec;
    rs_idx_t [IS_NUM-1:0]          is_idx;
    logic [IS_NUM-1:0]             is_found;

    // ------------------------------
    // Ready check
    // ------------------------------
    always_comb begin
        for (int i = 0; i < RS_ENTRIES; i++) begin
            ready_vec[i] = entries_i[i].valid
                        && entries_i[i].src1_rdy
                        && entries_i[i].src2_rdy
                        && fu_ready_i[entries_i[i].fu];
        end
    end

    // Fixed priority, lowest entry first
    pe_mult #(
        .IN_WIDTH (RS_ENTRIES),
        .OUT_NUM  (IS_NUM)
    ) u_issue_pe (
        .bit_i    (ready_vec),
        .enc_o    (is_idx),
        .valid_o  (is_found)
    );

    // ------------------------------
    // Issue routing
    // ------------------------------
    // Encoder fills outputs in order, so channels fill from 0 upward
    always_comb begin
        issue_sel_o   = '0;
        is_valid_o    = '0;
        is_tag_o      = '0;
        is_src1_tag_o = '0;
        is_src2_tag_o = '0;
        for (int c = 0; c < IS_NUM; c++) begin
            is_fu_o[c] = FU_ALU;
            if (is_found[c]) begin
                issue_sel_o[is_idx[c]] = 1'b1;
                is_valid_o[c]          = 1'b1;
                is_fu_o[c]             = entries_i[is_idx[c]].fu;
                is_tag_o[c]            = entries_i[is_idx[c]].dest_tag;
                // Source tags double as register file read addresses
                is_src1_tag_o[c]       = entries_i[is_idx[c]].src1_tag;
                is_src2_tag_o[c]       = entries_i[is_idx[c]].src2_tag;
            end
        end
    end

endmodule

/* src/rs_entry_array.sv */
/*
 * Entry storage of the reservation station.
 * Per entry priority is flush, dispatch write, issue release, then CDB wakeup.
 * The whole array is visible on entries_o for issue selection.
 */
`timescale 1ns/1ps

module rs_entry_array (
    input  logic                                    clk_i,
    input  logic                                    rst_i,
    input  logic                                    flush_i,
    input  rs_pkg::fu_t  [rs_pkg::DP_NUM-1:0]       dp_fu_i,
    input  rs_pkg::tag_t [rs_pkg::DP_NUM-1:0]       dp_tag_i,
    input  rs_pkg::tag_t [rs_pkg::DP_NUM-1:0]       dp_src1_tag_i,
    input  logic [rs_pkg::DP_NUM-1:0]               dp_src1_rdy_i,
    input  rs_pkg::tag_t [rs_pkg::DP_NUM-1:0]       dp_src2_tag_i,
    input  logic [rs_pkg::DP_NUM-1:0]               dp_src2_rdy_i,
    input  logic [rs_pkg::DP_NUM-1:0]               dp_sel_i,
    input  rs_pkg::rs_idx_t [rs_pkg::DP_NUM-1:0]    dp_entry_i,
    input  logic [rs_pkg::CDB_NUM-1:0]              cdb_valid_i,
    input  rs_pkg::tag_t [rs_pkg::CDB_NUM-1:0]      cdb_tag_i,
    input  logic [rs_pkg::RS_ENTRIES-1:0]           issue_sel_i,
    output rs_pkg::rs_entry_t [rs_pkg::RS_ENTRIES-1:0] entries_o
);

    import rs_pkg::*;

    rs_entry_t [RS_ENTRIES-1:0] entries;
    rs_entry_t [RS_ENTRIES-1:0] dp_word;
    logic [RS_ENTRIES-1:0]      dp_hit;
    logic [RS_ENTRIES-1:0]      wake1;
    logic [RS_ENTRIES-1:0]      wake2;

    // ------------------------------
    // Dispatch routing
    // ------------------------------
    always_comb begin
        dp_hit  = '0;
        dp_word = '0;
        for (int i = 0; i < RS_ENTRIES; i++) begin
            for (int s = 0; s < DP_NUM; s++) begin
                if (dp_sel_i[s] && (dp_entry_i[s] == rs_idx_t'(i))) begin
                    dp_hit[i]           = 1'b1;
                    dp_word[i].valid    = 1'b1;
                    dp_word[i].fu       = dp_fu_i[s];
                    dp_word[i].dest_tag = dp_tag_i[s];
                    dp_word[i].src1_tag = dp_src1_tag_i[s];
                    dp_word[i].src1_rdy = dp_src1_rdy_i[s];
                    dp_word[i].src2_tag = dp_src2_tag_i[s];
                    dp_word[i].src2_rdy = dp_src2_rdy_i[s];
                end
            end
        end
    end

    // ------------------------------
    // CDB tag compare
    // ------------------------------
    // Any valid bus may match either source
    always_comb begin
        wake1 = '0;
        wake2 = '0;
        for (int i = 0; i < RS_ENTRIES; i++) begin
            for (int c = 0; c < CDB_NUM; c++) begin
                if (cdb_valid_i[c] && (cdb_tag_i[c] == entries[i].src1_tag)) begin
                    wake1[i] = 1'b1;
                end
                if (cdb_valid_i[c] && (cdb_tag_i[c] == entries[i].src2_tag)) begin
                    wake2[i] = 1'b1;
                end
            end
        end
    end

    // ------------------------------
    // Entry update
    // ------------------------------
    always_ff @(posedge clk_i) begin
        for (int i = 0; i < RS_ENTRIES; i++) begin
            if (rst_i || flush_i) begin
                entries[i].valid <= 1'b0;
            end else if (dp_hit[i]) begin
                // New instruction, may reuse an entry issuing this cycle
                entries[i] <= dp_word[i];
            end else if (issue_sel_i[i]) begin
                entries[i].valid <= 1'b0;
            end else if (entries[i].valid) begin
                // Ready flags set independently
                if (wake1[i]) begin
                    entries[i].src1_rdy <= 1'b1;
                end
                if (wake2[i]) begin
                    entries[i].src2_rdy <= 1'b1;
                end
            end
        end
    end

    assign entries_o = entries;

endmodule

/* src/rs_alloc.sv */
/*
 * Entry allocation for dispatch.
 * Picks the lowest free entries for the valid dispatch slots and reports how
 * many entries the dispatcher may fill, saturated at DP_NUM.
 */
`timescale 1ns/1ps

module rs_alloc (
    input  rs_pkg::dp_cnt_t                         dp_num_i,
    input  logic [rs_pkg::RS_ENTRIES-1:0]           entry_valid_i,
    input  logic [rs_pkg::RS_ENTRIES-1:0]           issue_sel_i,
    output logic [rs_pkg::DP_NUM-1:0]               dp_sel_o,
    output rs_pkg::rs_idx_t [rs_pkg::DP_NUM-1:0]    dp_entry_o,
    output rs_pkg::dp_cnt_t                         avail_num_o
);

    import rs_pkg::*;

    logic [RS_ENTRIES-1:0] free_vec;
    logic [DP_NUM-1:0]     free_found;
    logic [RS_CNT_W-1:0]   free_cnt;

    // Entries leaving on an issue channel this cycle count as free
    assign free_vec = ~entry_valid_i | issue_sel_i;

    // ------------------------------
    // Free entry encoder
    // ------------------------------
    pe_mult #(
        .IN_WIDTH (RS_ENTRIES),
        .OUT_NUM  (DP_NUM)
    ) u_free_pe (
        .bit_i    (free_vec),
        .enc_o    (dp_entry_o),
        .valid_o  (free_found)
    );

    // Slot takes its entry only if one was found and the slot is in use
    for (genvar s = 0; s < DP_NUM; s++) begin : g_slot
        assign dp_sel_o[s] = free_found[s] && (dp_cnt_t'(s) < dp_num_i);
    end

    // ------------------------------
    // Available count
    // ------------------------------
    always_comb begin
        free_cnt = '0;
        for (int i = 0; i < RS_ENTRIES; i++) begin
            if (free_vec[i]) begin
                free_cnt = free_cnt + 1'b1;
            end
        end
        // Saturate at the dispatch width
        if (free_cnt >= RS_CNT_W'(DP_NUM)) begin
            avail_num_o = dp_cnt_t'(DP_NUM);
        end else begin
            avail_num_o = dp_cnt_t'(free_cnt);
        end
    end

endmodule

/* src/pe_mult.sv */
/*
 * Multi-output priority encoder.
 * Reports the indices of the lowest OUT_NUM set bits of bit_i, lowest first,
 * with a valid flag per output.
 */
`timescale 1ns/1ps

module pe_mult #(
    parameter int IN_WIDTH = 8,
    parameter int OUT_NUM  = 2
) (
    input  logic [IN_WIDTH-1:0]                      bit_i,
    output logic [OUT_NUM-1:0][$clog2(IN_WIDTH)-1:0] enc_o,
    output logic [OUT_NUM-1:0]                       valid_o
);

    localparam int IDX_W = $clog2(IN_WIDTH);

    always_comb begin
        logic [IN_WIDTH-1:0] remain;
        remain  = bit_i;
        enc_o   = '0;
        valid_o = '0;
        // One pass per output, each pass takes the lowest remaining bit
        for (int o = 0; o < OUT_NUM; o++) begin
            for (int b = 0; b < IN_WIDTH; b++) begin
                if (!valid_o[o] && remain[b]) begin
                    enc_o[o]   = IDX_W'(b);
                    valid_o[o] = 1'b1;
                    // Hide it from later passes
                    remain[b]  = 1'b0;
                end
            end
        end
    end

endmodule

/* src/rs_pkg.sv */
/*
 * Shared sizes and types of the reservation station.
 * RTL modules import it inside their bodies and use scoped names in port lists.
 */
package rs_pkg;

    // ------------------------------
    // Sizes
    // ------------------------------
    localparam int RS_ENTRIES = 8;
    localparam int DP_NUM     = 2;
    localparam int IS_NUM     = 2;
    localparam int CDB_NUM    = 2;
    localparam int TAG_W      = 6;
    localparam int FU_NUM     = 5;

    // Derived widths
    localparam int RS_IDX_W   = $clog2(RS_ENTRIES);
    localparam int DP_CNT_W   = $clog2(DP_NUM + 1);
    // Counter wide enough for 0..RS_ENTRIES
    localparam int RS_CNT_W   = $clog2(RS_ENTRIES + 1);

    // ------------------------------
    // Types
    // ------------------------------
    typedef logic [TAG_W-1:0]    tag_t;
    typedef logic [RS_IDX_W-1:0] rs_idx_t;
    typedef logic [DP_CNT_W-1:0] dp_cnt_t;

    // Unit class, also the index into fu_ready_i
    typedef enum logic [2:0] {
        FU_ALU   = 3'd0,
        FU_MULT  = 3'd1,
        FU_LOAD  = 3'd2,
        FU_STORE = 3'd3,
        FU_BR    = 3'd4
    } fu_t;

    // One station entry, 24 bits
    typedef struct packed {
        logic valid;
        fu_t  fu;
        tag_t dest_tag;
        tag_t src1_tag;
        logic src1_rdy;
        tag_t src2_tag;
        logic src2_rdy;
    } rs_entry_t;

endpackage
